// ==== dv/clic_tb.sv ====
// stops at the first mismatch with $fatal; expects NumSrc = 4 and the timer count to track reset
`default_nettype none

module clic_tb;
  import clic_csr_pkg::*;
  import clic_core_pkg::*;

  localparam int  ClkPeriod     = 8;
  localparam int  ResetCycles   = 5;
  localparam int  NumTests      = 6;
  localparam int  CyclesPerTest = 200;
  localparam pc_t RetPc         = '1;

  logic              clk;
  logic              arst_n_i;
  clic_csr_req_t     csr_req_i;
  word_t             rs1_data_i;
  pc_t               pc_i;
  logic [NumSrc-1:1] irq_i;
  word_t             csr_rdata_o;
  pc_t               int_addr_o;
  src_id_t           int_id_o;
  prio_t             int_prio_o;
  pc_sel_e           pc_sel_o;
  level_t            level_o;
  logic              interrupt_o;
  logic              tail_chain_o;

  // shadow copy of the CSR bank and the return stack
  logic [3:0]   m_mstatus;
  prio_t        m_thresh;
  clic_entry_t  m_entry [NumSrc];
  vec_addr_t    m_vec   [NumSrc];
  word_t        m_cmp;
  src_id_t      m_cur_id;
  stack_entry_t m_stack [$];
  word_t        tb_count;
  string        test_name;

  clic_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // expected value of the free-running counter
  always @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tb_count <= '0;
    end else begin
      tb_count <= tb_count + 32'd1;
    end
  end

  initial begin
    #((NumTests * CyclesPerTest + ResetCycles) * ClkPeriod);
    abort_run("watchdog expired before all tests finished");
  end

  task automatic abort_run(input string reason);
    $display("%s: %s", test_name, reason);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string what, input word_t exp, input word_t act);
    $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    $display("Simulation failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic expect_eq(input string what, input word_t exp, input word_t act);
    assert (exp == act) else report_mismatch(what, exp, act);
  endtask

  // invariants of every settled cycle
  a_mie_keeps_normal: assert property (@(negedge clk) disable iff (!arst_n_i)
                                       !m_mstatus[3] |-> (pc_sel_o == PcNormal))
    else report_mismatch("pc_sel_o with mie clear", PcNormal, pc_sel_o);
  a_mie_passes_pc: assert property (@(negedge clk) disable iff (!arst_n_i)
                                    !m_mstatus[3] |-> (int_addr_o == pc_i))
    else report_mismatch("int_addr_o with mie clear", pc_i, int_addr_o);
  a_irq_uses_vec: assert property (@(negedge clk) disable iff (!arst_n_i)
                                   interrupt_o |-> (int_addr_o == {m_vec[int_id_o], 2'b00}))
    else report_mismatch("int_addr_o on interrupt", {m_vec[int_id_o], 2'b00}, int_addr_o);

  function automatic word_t csr_result(word_t cur, csr_op_e op, logic imm, word_t rs1);
    word_t src;
    src = imm ? {27'd0, rs1[4:0]} : rs1;
    case (op)
      CsrOpWrite: return src;
      CsrOpSet:   return cur | src;
      CsrOpClear: return cur & ~src;
      default:    return cur;
    endcase
  endfunction

  function automatic word_t model_read(csr_addr_t addr);
    word_t val;
    val = '0;
    if (addr == MStatusAddr) val = {28'd0, m_mstatus};
    if (addr == MIntThreshAddr) val = word_t'(m_thresh);
    if (addr == TimerCmpAddr) val = m_cmp;
    if (addr == StackDepthAddr) val = word_t'(m_stack.size());
    for (int k = 0; k < NumSrc; k++) begin
      if (addr == VecCsrBase + csr_addr_t'(k)) val = word_t'(m_vec[k]);
      if (addr == EntryCsrBase + csr_addr_t'(k)) val = word_t'(m_entry[k]);
    end
    return val;
  endfunction

  function automatic pc_t rand_pc();
    return pc_t'($urandom) & ~32'h3;
  endfunction

  task automatic csr_access(input csr_addr_t addr, input csr_op_e op, input logic imm,
                            input word_t rs1);
    word_t res;
    res = csr_result(model_read(addr), op, imm, rs1);
    @(posedge clk);
    csr_req_i  <= '{en: 1'b1, addr: addr, op: op, use_imm: imm};
    rs1_data_i <= rs1;
    @(posedge clk);
    csr_req_i <= '0;
    if (addr == MStatusAddr) m_mstatus = res[3:0];
    if (addr == MIntThreshAddr) m_thresh = prio_t'(res);
    if (addr == TimerCmpAddr) m_cmp = res;
    for (int k = 0; k < NumSrc; k++) begin
      if (addr == VecCsrBase + csr_addr_t'(k)) m_vec[k] = res[29:0];
      if (addr == EntryCsrBase + csr_addr_t'(k)) m_entry[k] = res[4:0];
    end
  endtask

  task automatic csr_check(input csr_addr_t addr, input string what);
    @(posedge clk);
    csr_req_i <= '{en: 1'b0, addr: addr, op: CsrOpNone, use_imm: 1'b0};
    @(negedge clk);
    expect_eq(what, model_read(addr), csr_rdata_o);
  endtask

  task automatic strobe_irq(input logic [NumSrc-1:1] mask);
    @(posedge clk);
    irq_i <= mask;
    @(posedge clk);
    irq_i <= '0;
    for (int k = 1; k < NumSrc; k++) begin
      if (mask[k]) m_entry[k].pending = 1'b1;
    end
  endtask

  task automatic wait_interrupt(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (!interrupt_o && n < max_cycles) begin
      n++;
      @(negedge clk);
    end
    if (!interrupt_o) abort_run("interrupt_o did not rise in time");
  endtask

  // top priority among eligible sources, then the highest index holding it
  task automatic model_best(output logic found, output src_id_t id, output prio_t prio);
    found = 1'b0;
    prio  = '0;
    id    = '0;
    for (int k = 0; k < NumSrc; k++) begin
      if (m_entry[k].enabled && m_entry[k].pending && m_entry[k].prio >= m_thresh &&
          (!found || m_entry[k].prio > prio)) begin
        found = 1'b1;
        prio  = m_entry[k].prio;
      end
    end
    for (int k = 0; k < NumSrc; k++) begin
      if (found && m_entry[k].enabled && m_entry[k].pending && m_entry[k].prio == prio) begin
        id = src_id_t'(k);
      end
    end
  endtask

  // compare a take or tail-chain cycle, then advance the model past its edge
  task automatic check_entry(input logic tail);
    logic         found;
    src_id_t      id;
    prio_t        prio;
    stack_entry_t ctx;
    model_best(found, id, prio);
    if (!found) abort_run("model holds no eligible source");
    expect_eq("interrupt_o", 1, interrupt_o);
    expect_eq("tail_chain_o", word_t'(tail), tail_chain_o);
    expect_eq("int_id_o", id, int_id_o);
    expect_eq("int_prio_o", prio, int_prio_o);
    expect_eq("int_addr_o", {m_vec[id], 2'b00}, int_addr_o);
    ctx.pc     = pc_i;
    ctx.thresh = m_thresh;
    ctx.id     = m_cur_id;
    if (!tail) m_stack.push_back(ctx);
    m_thresh            = prio;
    m_entry[id].pending = 1'b0;
    m_cur_id            = id;
  endtask

  initial begin
    word_t             seed;
    logic [NumSrc-1:1] mask;
    src_id_t           s;
    stack_entry_t      saved;
    seed       = $urandom(83);
    csr_req_i  = '0;
    rs1_data_i = '0;
    pc_i       = '0;
    irq_i      = '0;
    arst_n_i   = 1'b0;
    m_mstatus  = '0;
    m_thresh   = '0;
    m_cmp      = '0;
    m_cur_id   = '0;
    for (int k = 0; k < NumSrc; k++) begin
      m_entry[k] = '0;
      m_vec[k]   = '0;
    end
    test_name = "reset";
    repeat (ResetCycles) @(posedge clk);
    arst_n_i <= 1'b1;

    test_name = "csr_access";
    csr_access(MIntThreshAddr, CsrOpWrite, 1'b0, $urandom);
    csr_check(MIntThreshAddr, "thresh csrrw");
    csr_access(MIntThreshAddr, CsrOpSet, 1'b1, $urandom);
    csr_check(MIntThreshAddr, "thresh csrrsi");
    csr_access(MIntThreshAddr, CsrOpClear, 1'b0, $urandom);
    csr_check(MIntThreshAddr, "thresh csrrc");
    for (int k = 0; k < NumSrc; k++) begin
      csr_access(EntryCsrBase + csr_addr_t'(k), CsrOpWrite, 1'b0, $urandom);
      csr_check(EntryCsrBase + csr_addr_t'(k), "entry csrrw");
      csr_access(EntryCsrBase + csr_addr_t'(k), CsrOpSet, 1'b1, $urandom);
      csr_check(EntryCsrBase + csr_addr_t'(k), "entry csrrsi");
      csr_access(EntryCsrBase + csr_addr_t'(k), CsrOpClear, 1'b1, $urandom);
      csr_check(EntryCsrBase + csr_addr_t'(k), "entry csrrci");
      csr_access(VecCsrBase + csr_addr_t'(k), CsrOpWrite, 1'b0, $urandom);
      csr_check(VecCsrBase + csr_addr_t'(k), "vector csrrw");
      csr_access(VecCsrBase + csr_addr_t'(k), CsrOpSet, 1'b1, $urandom);
      csr_check(VecCsrBase + csr_addr_t'(k), "vector csrrsi");
      csr_access(VecCsrBase + csr_addr_t'(k), CsrOpClear, 1'b0, $urandom);
      csr_check(VecCsrBase + csr_addr_t'(k), "vector csrrc");
    end
    // only reserved mstatus bits so mie stays off
    csr_access(MStatusAddr, CsrOpWrite, 1'b0, 32'h7);
    csr_check(MStatusAddr, "mstatus csrrw");
    csr_access(MStatusAddr, CsrOpClear, 1'b1, 32'h1f);
    csr_check(MStatusAddr, "mstatus csrrci");
    csr_check(StackDepthAddr, "depth after reset");
    csr_check(12'h123, "unknown address");
    csr_check(12'hfff, "unknown address");

    test_name = "masking";
    csr_access(MIntThreshAddr, CsrOpWrite, 1'b0, 32'd1);
    csr_access(EntryCsrBase, CsrOpWrite, 1'b0, 32'h0);
    for (int k = 1; k < NumSrc; k++) begin
      csr_access(EntryCsrBase + csr_addr_t'(k), CsrOpWrite, 1'b0, 32'h16);
    end
    strobe_irq('1);
    repeat (6) begin
      @(posedge clk);
      pc_i <= ($urandom % 2 == 0) ? RetPc : rand_pc();
      @(negedge clk);
      expect_eq("interrupt_o", 0, interrupt_o);
      expect_eq("int_addr_o", pc_i, int_addr_o);
      expect_eq("pc_sel_o", PcNormal, pc_sel_o);
    end

    test_name = "take";
    @(posedge clk);
    pc_i <= rand_pc();
    csr_access(EntryCsrBase, CsrOpWrite, 1'b0, 32'h0);
    // priorities 1..3 so that ties are common
    for (int k = 1; k < NumSrc; k++) begin
      csr_access(EntryCsrBase + csr_addr_t'(k), CsrOpWrite, 1'b0,
                 (word_t'(1 + $urandom % 3) << 2) | 32'h2);
    end
    csr_access(MIntThreshAddr, CsrOpWrite, 1'b0, 32'd0);
    csr_access(MStatusAddr, CsrOpWrite, 1'b0, 32'h8);
    repeat ($urandom % 4) @(posedge clk);
    mask = '0;
    while (mask == '0) mask = $urandom;
    strobe_irq(mask);
    wait_interrupt(CyclesPerTest);
    check_entry(1'b0);
    csr_check(MIntThreshAddr, "thresh after take");
    csr_check(EntryCsrBase + csr_addr_t'(m_cur_id), "entry after take");
    csr_check(StackDepthAddr, "depth after take");
    expect_eq("level_o", m_stack.size(), level_o);

    test_name = "nest_return";
    s = (m_cur_id == 2'd3) ? 2'd1 : 2'd3;
    csr_access(EntryCsrBase + csr_addr_t'(s), CsrOpWrite, 1'b0, 32'h1e);
    @(posedge clk);
    pc_i <= rand_pc();
    mask    = '0;
    mask[s] = 1'b1;
    strobe_irq(mask);
    wait_interrupt(CyclesPerTest);
    check_entry(1'b0);
    csr_check(StackDepthAddr, "depth after nest");
    @(posedge clk);
    pc_i <= RetPc;
    @(negedge clk);
    saved = m_stack[m_stack.size() - 1];
    expect_eq("pc_sel_o on return", PcInterrupt, pc_sel_o);
    expect_eq("interrupt_o on return", 0, interrupt_o);
    expect_eq("int_addr_o on return", saved.pc, int_addr_o);
    expect_eq("int_prio_o on return", saved.thresh, int_prio_o);
    expect_eq("int_id_o on return", saved.id, int_id_o);
    m_thresh = saved.thresh;
    m_cur_id = saved.id;
    m_stack.pop_back();
    @(posedge clk);
    pc_i <= rand_pc();
    csr_check(StackDepthAddr, "depth after return");
    csr_check(MIntThreshAddr, "thresh after return");

    test_name = "tail_chain";
    csr_access(EntryCsrBase + csr_addr_t'(s), CsrOpWrite, 1'b0, {27'd0, m_thresh, 2'b10});
    strobe_irq(mask);
    @(posedge clk);
    pc_i <= RetPc;
    @(negedge clk);
    check_entry(1'b1);
    @(posedge clk);
    pc_i <= rand_pc();
    csr_check(StackDepthAddr, "depth after tail chain");
    csr_check(EntryCsrBase + csr_addr_t'(m_cur_id), "entry after tail chain");

    test_name = "timer";
    csr_access(MStatusAddr, CsrOpWrite, 1'b0, 32'h0);
    csr_access(MIntThreshAddr, CsrOpWrite, 1'b0, 32'd0);
    for (int k = 0; k < NumSrc; k++) begin
      csr_access(EntryCsrBase + csr_addr_t'(k), CsrOpWrite, 1'b0, (k == 0) ? 32'h12 : 32'h0);
    end
    csr_access(MStatusAddr, CsrOpWrite, 1'b0, 32'h8);
    csr_access(TimerCmpAddr, CsrOpWrite, 1'b0, tb_count + 32'd20);
    csr_check(TimerCmpAddr, "timer compare");
    wait_interrupt(CyclesPerTest);
    // match cycle, pend at its edge, take in the cycle after
    expect_eq("counter at timer take", m_cmp + 32'd1, tb_count);
    // pended by the compare match
    m_entry[0].pending = 1'b1;
    check_entry(1'b0);
    csr_check(StackDepthAddr, "depth after timer take");
    csr_check(EntryCsrBase, "timer entry after take");

    $display("Simulation passed");
    $finish;
  end

endmodule : clic_tb

`default_nettype wire

// ==== logic/clic_core_pkg.sv ====
// controller-side types; source count and priority width fix the stack depth at one slot per level
`default_nettype none

package clic_core_pkg;

  localparam int unsigned NumSrc     = 4;
  localparam int unsigned PrioWidth  = 3;
  localparam int unsigned StackDepth = 8;

  typedef logic [PrioWidth-1:0]      prio_t;
  typedef logic [$clog2(NumSrc)-1:0] src_id_t;

  // counts 0..StackDepth inclusive
  typedef logic [3:0] level_t;

  typedef logic [31:0] pc_t;

  // handler word address, shifted left by two on use
  typedef logic [29:0] vec_addr_t;

  // pending sits at the LSB so csrrsi/csrrci reach it
  typedef struct packed {
    prio_t prio;
    logic  enabled;
    logic  pending;
  } clic_entry_t;

  // saved context, 37 bits
  typedef struct packed {
    pc_t     pc;
    prio_t   thresh;
    src_id_t id;
  } stack_entry_t;

  typedef enum logic {
    PcNormal    = 1'b0,
    PcInterrupt = 1'b1
  } pc_sel_e;

  // mie at bit 3, lower bits reserved
  typedef struct packed {
    logic       mie;
    logic [2:0] rsvd;
  } mstatus_t;

endpackage : clic_core_pkg

`default_nettype wire

// ==== logic/clic_csr_pkg.sv ====
// CSR map and request format; the 5-bit immediate travels in rs1_data_i[4:0] when use_imm is set
`default_nettype none

package clic_csr_pkg;

  typedef logic [11:0] csr_addr_t;
  typedef logic [31:0] word_t;

  // csrrw / csrrs / csrrc, plus idle
  typedef enum logic [1:0] {
    CsrOpNone  = 2'b00,
    CsrOpWrite = 2'b01,
    CsrOpSet   = 2'b10,
    CsrOpClear = 2'b11
  } csr_op_e;

  // 16 bits: en, addr, op, use_imm
  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    csr_op_e   op;
    // take rs1_data_i[4:0] zero-extended instead of full rs1
    logic      use_imm;
  } clic_csr_req_t;

  // machine-level registers
  localparam csr_addr_t MStatusAddr    = 12'h300;
  localparam csr_addr_t MIntThreshAddr = 12'h347;
  localparam csr_addr_t StackDepthAddr = 12'h350;
  localparam csr_addr_t TimerCmpAddr   = 12'h400;

  // per-source banks, offset by source index
  localparam csr_addr_t VecCsrBase   = 12'hb00;
  localparam csr_addr_t EntryCsrBase = 12'hb40;

endpackage : clic_csr_pkg

`default_nettype wire

// ==== logic/clic_csr_reg.sv ====
// data_t must be at most 32 bits; a hardware write wins over a software write in the same cycle
`default_nettype none

module clic_csr_reg #(
  parameter clic_csr_pkg::csr_addr_t Addr = '0,
  parameter type data_t = logic [31:0]
) (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  clic_csr_pkg::clic_csr_req_t csr_req_i,
  input  clic_csr_pkg::word_t         rs1_data_i,
  input  logic                        ext_we_i,
  input  data_t                       ext_data_i,
  output data_t                       data_o,
  output clic_csr_pkg::word_t         rdata_o
);
  import clic_csr_pkg::*;

  data_t                    data_q;
  logic [$bits(data_t)-1:0] raw_q;
  word_t                    cur;
  word_t                    operand;
  word_t                    nxt;
  logic                     addr_hit;
  logic                     sw_we;

  assign addr_hit = (csr_req_i.addr == Addr);
  assign sw_we    = csr_req_i.en && addr_hit && (csr_req_i.op != CsrOpNone);

  // zimm is zero-extended
  assign operand = csr_req_i.use_imm ? word_t'(rs1_data_i[4:0]) : rs1_data_i;

  assign raw_q = data_q;
  assign cur   = word_t'(raw_q);

  always_comb begin
    case (csr_req_i.op)
      CsrOpWrite: nxt = operand;
      CsrOpSet:   nxt = cur | operand;
      CsrOpClear: nxt = cur & ~operand;
      default:    nxt = cur;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_q <= '0;
    end else if (ext_we_i) begin
      data_q <= ext_data_i;
    end else if (sw_we) begin
      // upper operand bits fall away for narrow registers
      data_q <= data_t'(nxt[$bits(data_t)-1:0]);
    end
  end

  assign data_o = data_q;

  // zero when not addressed, so the parent can OR reads together
  assign rdata_o = addr_hit ? cur : '0;

endmodule : clic_csr_reg

`default_nettype wire

// ==== logic/clic_epc_stack.sv ====
// push when full and pop when empty are dropped; data_o reads zero on an empty stack
`default_nettype none

module clic_epc_stack (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  logic                        push_i,
  input  logic                        pop_i,
  input  clic_core_pkg::stack_entry_t data_i,
  output clic_core_pkg::stack_entry_t data_o,
  output clic_core_pkg::level_t       level_o
);
  import clic_core_pkg::*;

  stack_entry_t                    mem_q [StackDepth];
  level_t                          level_q;
  logic [$clog2(StackDepth)-1:0]   wr_idx;
  logic [$clog2(StackDepth)-1:0]   top_idx;
  logic                            full;
  logic                            empty;

  assign full    = (level_q == level_t'(StackDepth));
  assign empty   = (level_q == '0);
  assign wr_idx  = level_q[$clog2(StackDepth)-1:0];
  assign top_idx = wr_idx - 1'b1;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      level_q <= '0;
    end else if (push_i && !full) begin
      level_q <= level_q + 1'b1;
    end else if (pop_i && !empty) begin
      level_q <= level_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (push_i && !full) begin
      mem_q[wr_idx] <= data_i;
    end
  end

  assign data_o  = empty ? '0 : mem_q[top_idx];
  assign level_o = level_q;

endmodule : clic_epc_stack

`default_nettype wire

// ==== logic/clic_prio_scan.sv ====
// purely combinational; eligible means enabled, pending and priority at or above the threshold
`default_nettype none

module clic_prio_scan (
  input  clic_core_pkg::clic_entry_t entries_i [clic_core_pkg::NumSrc],
  input  clic_core_pkg::prio_t       thresh_i,
  output logic                       found_o,
  output clic_core_pkg::src_id_t     best_id_o,
  output clic_core_pkg::prio_t       best_prio_o
);
  import clic_core_pkg::*;

  logic    found;
  src_id_t best_id;
  prio_t   best_prio;

  // linear walk, running max starts at the threshold
  always_comb begin
    found     = 1'b0;
    best_id   = '0;
    best_prio = thresh_i;
    for (int k = 0; k < NumSrc; k++) begin
      // >= lets a later index take a tie
      if (entries_i[k].enabled && entries_i[k].pending &&
          (entries_i[k].prio >= best_prio)) begin
        found     = 1'b1;
        best_id   = src_id_t'(k);
        best_prio = entries_i[k].prio;
      end
    end
  end

  assign found_o     = found;
  assign best_id_o   = best_id;
  assign best_prio_o = best_prio;

endmodule : clic_prio_scan

`default_nettype wire

// ==== logic/clic_timer.sv ====
// 32-bit wrapping counter; a compare value of zero disables the match strobe
`default_nettype none

module clic_timer (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  clic_csr_pkg::clic_csr_req_t csr_req_i,
  input  clic_csr_pkg::word_t         rs1_data_i,
  output clic_csr_pkg::word_t         rdata_o,
  output logic                        match_o
);
  import clic_csr_pkg::*;

  word_t count_q;
  word_t cmp;

  // compare register, software only
  clic_csr_reg #(
    .Addr  (TimerCmpAddr),
    .data_t(word_t)
  ) u_cmp (
    .clk       (clk),
    .arst_n_i  (arst_n_i),
    .csr_req_i (csr_req_i),
    .rs1_data_i(rs1_data_i),
    .ext_we_i  (1'b0),
    .ext_data_i('0),
    .data_o    (cmp),
    .rdata_o   (rdata_o)
  );

  // free-running, wraps at 2^32
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 32'd1;
    end
  end

  // one cycle wide since the counter moves on every cycle
  assign match_o = (cmp != '0) && (count_q == cmp);

endmodule : clic_timer

`default_nettype wire

// ==== logic/clic_top.sv ====
// all-ones pc_i marks a return; pc_i must hold steady through the decision cycle, no back-pressure
`default_nettype none

module clic_top (
  input  logic                              clk,
  input  logic                              arst_n_i,
  input  clic_csr_pkg::clic_csr_req_t       csr_req_i,
  input  clic_csr_pkg::word_t               rs1_data_i,
  input  clic_core_pkg::pc_t                pc_i,
  input  logic [clic_core_pkg::NumSrc-1:1]  irq_i,
  output clic_csr_pkg::word_t               csr_rdata_o,
  output clic_core_pkg::pc_t                int_addr_o,
  output clic_core_pkg::src_id_t            int_id_o,
  output clic_core_pkg::prio_t              int_prio_o,
  output clic_core_pkg::pc_sel_e            pc_sel_o,
  output clic_core_pkg::level_t             level_o,
  output logic                              interrupt_o,
  output logic                              tail_chain_o
);
  import clic_csr_pkg::*;
  import clic_core_pkg::*;

  mstatus_t     mstatus_q;
  prio_t        thresh_q;
  vec_addr_t    vec_q        [NumSrc];
  clic_entry_t  entry_q      [NumSrc];
  word_t        mstatus_rdata;
  word_t        thresh_rdata;
  word_t        timer_rdata;
  word_t        vec_rdata    [NumSrc];
  word_t        entry_rdata  [NumSrc];
  word_t        rdata;

  logic         thresh_we;
  prio_t        thresh_wd;
  logic         entry_we     [NumSrc];
  clic_entry_t  entry_wd     [NumSrc];

  logic         timer_match;
  logic [NumSrc-1:0] src_pend;
  logic         found;
  src_id_t      best_id;
  prio_t        best_prio;
  logic         take;
  logic         tail;
  logic         ret;
  logic         is_ret_pc;
  stack_entry_t push_data;
  stack_entry_t stack_top;
  src_id_t      cur_id_q;

  clic_csr_reg #(
    .Addr  (MStatusAddr),
    .data_t(mstatus_t)
  ) u_mstatus (
    .clk, .arst_n_i, .csr_req_i, .rs1_data_i,
    .ext_we_i  (1'b0),
    .ext_data_i('0),
    .data_o    (mstatus_q),
    .rdata_o   (mstatus_rdata)
  );

  clic_csr_reg #(
    .Addr  (MIntThreshAddr),
    .data_t(prio_t)
  ) u_thresh (
    .clk, .arst_n_i, .csr_req_i, .rs1_data_i,
    .ext_we_i  (thresh_we),
    .ext_data_i(thresh_wd),
    .data_o    (thresh_q),
    .rdata_o   (thresh_rdata)
  );

  for (genvar k = 0; k < NumSrc; k++) begin : gen_src
    clic_csr_reg #(
      .Addr  (VecCsrBase + csr_addr_t'(k)),
      .data_t(vec_addr_t)
    ) u_vec (
      .clk, .arst_n_i, .csr_req_i, .rs1_data_i,
      .ext_we_i  (1'b0),
      .ext_data_i('0),
      .data_o    (vec_q[k]),
      .rdata_o   (vec_rdata[k])
    );

    clic_csr_reg #(
      .Addr  (EntryCsrBase + csr_addr_t'(k)),
      .data_t(clic_entry_t)
    ) u_entry (
      .clk, .arst_n_i, .csr_req_i, .rs1_data_i,
      .ext_we_i  (entry_we[k]),
      .ext_data_i(entry_wd[k]),
      .data_o    (entry_q[k]),
      .rdata_o   (entry_rdata[k])
    );
  end

  clic_timer u_timer (
    .clk, .arst_n_i, .csr_req_i, .rs1_data_i,
    .rdata_o(timer_rdata),
    .match_o(timer_match)
  );

  clic_prio_scan u_scan (
    .entries_i  (entry_q),
    .thresh_i   (thresh_q),
    .found_o    (found),
    .best_id_o  (best_id),
    .best_prio_o(best_prio)
  );

  assign push_data = '{pc: pc_i, thresh: thresh_q, id: cur_id_q};

  clic_epc_stack u_stack (
    .clk, .arst_n_i,
    .push_i (take),
    .pop_i  (ret),
    .data_i (push_data),
    .data_o (stack_top),
    .level_o(level_o)
  );

  // source 0 is the timer, the rest are external strobes
  assign src_pend  = {irq_i, timer_match};
  assign is_ret_pc = (pc_i == '1);

  // take beats tail-chain beats return
  always_comb begin
    take = 1'b0;
    tail = 1'b0;
    ret  = 1'b0;
    if (mstatus_q.mie) begin
      if (found && (best_prio > thresh_q)) begin
        take = 1'b1;
      end else if (is_ret_pc && found) begin
        tail = 1'b1;
      end else if (is_ret_pc) begin
        ret = 1'b1;
      end
    end
  end

  assign interrupt_o  = take | tail;
  assign tail_chain_o = tail;
  assign pc_sel_o     = (take | tail | ret) ? PcInterrupt : PcNormal;

  always_comb begin
    if (take || tail) begin
      int_addr_o = {vec_q[best_id], 2'b00};
      int_id_o   = best_id;
      int_prio_o = best_prio;
    end else if (ret) begin
      int_addr_o = stack_top.pc;
      int_id_o   = stack_top.id;
      int_prio_o = stack_top.thresh;
    end else begin
      int_addr_o = pc_i;
      int_id_o   = cur_id_q;
      int_prio_o = thresh_q;
    end
  end

  // threshold follows the taken priority, or comes back from the stack
  assign thresh_we = take | tail | ret;
  assign thresh_wd = ret ? stack_top.thresh : best_prio;

  // pend set from strobes, clear on take; clear wins
  always_comb begin
    for (int k = 0; k < NumSrc; k++) begin
      entry_we[k] = 1'b0;
      entry_wd[k] = entry_q[k];
      if (src_pend[k]) begin
        entry_we[k]         = 1'b1;
        entry_wd[k].pending = 1'b1;
      end
      if ((take || tail) && (best_id == src_id_t'(k))) begin
        entry_we[k]         = 1'b1;
        entry_wd[k].pending = 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cur_id_q <= '0;
    end else if (take || tail) begin
      cur_id_q <= best_id;
    end else if (ret) begin
      cur_id_q <= stack_top.id;
    end
  end

  // every register reads zero unless addressed
  always_comb begin
    rdata = mstatus_rdata | thresh_rdata | timer_rdata;
    if (csr_req_i.addr == StackDepthAddr) begin
      rdata = rdata | word_t'(level_o);
    end
    for (int k = 0; k < NumSrc; k++) begin
      rdata = rdata | vec_rdata[k] | entry_rdata[k];
    end
  end

  assign csr_rdata_o = rdata;

endmodule : clic_top

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module clic_tb -f tb.f -o clic_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed"
  exit "$status"
fi

./obj_dir/clic_tb_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation reported failure"
  exit "$status"
fi

exit 0

// ==== tb.f ====
logic/clic_csr_pkg.sv
logic/clic_core_pkg.sv
logic/clic_csr_reg.sv
logic/clic_timer.sv
logic/clic_prio_scan.sv
logic/clic_epc_stack.sv
logic/clic_top.sv
dv/clic_tb.sv
